// File: src/exec_pkg.sv
package exec_pkg;

    // ----------------------------------------
    // cluster geometry
    // ----------------------------------------

    // number of execute lanes in the cluster
    localparam int num_lanes  = 4;
    localparam int lane_idx_w = (num_lanes > 1) ? $clog2(num_lanes) : 1;

    // ----------------------------------------
    // encodings
    // ----------------------------------------

    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_ADC   = 4'd1,
        OP_SUB   = 4'd2,
        OP_SBB   = 4'd3,
        OP_AND   = 4'd4,
        OP_OR    = 4'd5,
        OP_XOR   = 4'd6,
        OP_NOT   = 4'd7,
        OP_SETCC = 4'd8,
        OP_JCC   = 4'd9
    } exec_op_e;

    // operand size, 3 is unused and treated as 32 bit
    typedef enum logic [1:0] {
        SZ_8  = 2'd0,
        SZ_16 = 2'd1,
        SZ_32 = 2'd2
    } exec_size_e;

    // ----------------------------------------
    // command and result
    // ----------------------------------------

    // arithmetic flags, no af
    typedef struct packed {
        logic of;
        logic sf;
        logic zf;
        logic pf;
        logic cf;
    } exec_flags_t;

    typedef struct packed {
        exec_op_e    op;
        // x86 condition index for setcc and jcc
        logic [3:0]  cond;
        exec_size_e  size;
        logic [31:0] src;
        logic [31:0] dst;
        logic [31:0] eip;
        logic [31:0] disp;
        exec_flags_t flags;
    } exec_cmd_t;

    typedef struct packed {
        logic [31:0] result;
        exec_flags_t flags;
        // jcc taken
        logic        branch;
        logic [31:0] branch_eip;
    } exec_res_t;

endpackage

// File: src/exec_condition.sv
`timescale 1ns/1ps

module exec_condition (
    input  exec_pkg::exec_flags_t flags,
    input  logic [3:0]            cond,
    output logic                  taken
);

    import exec_pkg::*;

    // the eight base conditions, indexed by cond[3:1]
    logic [7:0] base;
    logic       sf_ne_of;

    assign sf_ne_of = flags.sf ^ flags.of;

    always_comb begin
        // o / no
        base[0] = flags.of;
        // b / ae
        base[1] = flags.cf;
        // e / ne
        base[2] = flags.zf;
        // be / a
        base[3] = flags.cf | flags.zf;
        // s / ns
        base[4] = flags.sf;
        // p / np
        base[5] = flags.pf;
        // l / ge
        base[6] = sf_ne_of;
        // le / g
        base[7] = flags.zf | sf_ne_of;
    end

    // odd index is the inverted form
    assign taken = base[cond[3:1]] ^ cond[0];

endmodule

// File: src/exec_dispatch.sv
`timescale 1ns/1ps

module exec_dispatch (
    input  logic                                clk,
    input  logic                                rst_n,

    // command input port
    input  logic                                cmd_valid,
    input  exec_pkg::exec_cmd_t                 cmd,
    output logic                                cmd_ready,

    // towards the lanes
    output logic [exec_pkg::num_lanes-1:0]      lane_in_valid,
    output exec_pkg::exec_cmd_t                 lane_cmd,
    input  logic [exec_pkg::num_lanes-1:0]      lane_in_ready
);

    import exec_pkg::*;

    // lane whose turn it is to take the next command
    logic [lane_idx_w-1:0] ptr;
    logic                  in_xfer;

    // ----------------------------------------
    // steering
    // ----------------------------------------

    assign cmd_ready = lane_in_ready[ptr];
    assign in_xfer   = cmd_valid && cmd_ready;

    // all lanes see the same payload, only one sees valid
    assign lane_cmd  = cmd;

    always_comb begin
        lane_in_valid      = '0;
        lane_in_valid[ptr] = cmd_valid;
    end

    // ----------------------------------------
    // turn pointer
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (in_xfer) begin
            if (ptr == lane_idx_w'(num_lanes - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

// File: src/exec_lane.sv
`timescale 1ns/1ps

module exec_lane (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 in_valid,
    input  exec_pkg::exec_cmd_t  cmd,
    output logic                 in_ready,

    output logic                 res_valid,
    output exec_pkg::exec_res_t  res,
    input  logic                 res_ready
);

    import exec_pkg::*;

    // ----------------------------------------
    // operand preparation
    // ----------------------------------------

    logic [31:0] size_mask;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic        cin;
    logic [32:0] add_raw;
    logic [32:0] sub_raw;
    logic [32:0] alu_raw;
    logic [31:0] alu_res;
    logic [31:0] disp_ext;
    logic [31:0] target_sum;
    logic        cond_taken;
    logic        a_top;
    logic        b_top;
    logic        r_top;
    logic        carry_out;
    logic        is_sub;
    exec_res_t   res_d;
    exec_res_t   res_q;

    // sign bit position depends on operand size
    function automatic logic top_bit(input logic [31:0] v, input exec_size_e sz);
        case (sz)
            SZ_8:    top_bit = v[7];
            SZ_16:   top_bit = v[15];
            default: top_bit = v[31];
        endcase
    endfunction

    always_comb begin
        case (cmd.size)
            SZ_8:    size_mask = 32'h0000_00ff;
            SZ_16:   size_mask = 32'h0000_ffff;
            default: size_mask = 32'hffff_ffff;
        endcase
    end

    assign op_a = cmd.dst & size_mask;
    assign op_b = cmd.src & size_mask;
    assign cin  = ((cmd.op == OP_ADC) || (cmd.op == OP_SBB)) ? cmd.flags.cf : 1'b0;

    // operands are masked, so the bit above the size is carry or borrow
    assign add_raw = {1'b0, op_a} + {1'b0, op_b} + {32'd0, cin};
    assign sub_raw = {1'b0, op_a} - {1'b0, op_b} - {32'd0, cin};
    assign is_sub  = (cmd.op == OP_SUB) || (cmd.op == OP_SBB);

    // ----------------------------------------
    // alu
    // ----------------------------------------

    always_comb begin
        case (cmd.op)
            OP_ADD, OP_ADC: alu_raw = add_raw;
            OP_SUB, OP_SBB: alu_raw = sub_raw;
            OP_AND:         alu_raw = {1'b0, op_a & op_b};
            OP_OR:          alu_raw = {1'b0, op_a | op_b};
            OP_XOR:         alu_raw = {1'b0, op_a ^ op_b};
            OP_NOT:         alu_raw = {1'b0, ~op_a};
            OP_SETCC:       alu_raw = {32'd0, cond_taken};
            default:        alu_raw = '0;
        endcase
    end

    assign alu_res = alu_raw[31:0] & size_mask;

    always_comb begin
        case (cmd.size)
            SZ_8:    carry_out = alu_raw[8];
            SZ_16:   carry_out = alu_raw[16];
            default: carry_out = alu_raw[32];
        endcase
    end

    assign a_top = top_bit(op_a, cmd.size);
    assign b_top = top_bit(op_b, cmd.size);
    assign r_top = top_bit(alu_res, cmd.size);

    exec_condition exec_condition_i (
        .flags (cmd.flags),
        .cond  (cmd.cond),
        .taken (cond_taken)
    );

    // ----------------------------------------
    // branch target
    // ----------------------------------------

    always_comb begin
        case (cmd.size)
            SZ_8:    disp_ext = {{24{cmd.disp[7]}}, cmd.disp[7:0]};
            SZ_16:   disp_ext = {{16{cmd.disp[15]}}, cmd.disp[15:0]};
            default: disp_ext = cmd.disp;
        endcase
    end

    assign target_sum = cmd.eip + disp_ext;

    // ----------------------------------------
    // result assembly
    // ----------------------------------------

    always_comb begin
        res_d            = '0;
        res_d.result     = alu_res;
        res_d.flags      = cmd.flags;
        res_d.branch_eip = (cmd.size == SZ_16) ? {16'd0, target_sum[15:0]} : target_sum;
        case (cmd.op)
            OP_ADD, OP_ADC, OP_SUB, OP_SBB: begin
                res_d.flags.cf = carry_out;
                // sub overflows when operand signs differ
                res_d.flags.of = is_sub ? ((a_top != b_top) && (r_top != a_top))
                                        : ((a_top == b_top) && (r_top != a_top));
                res_d.flags.zf = (alu_res == 32'd0);
                res_d.flags.sf = r_top;
                res_d.flags.pf = ~^alu_res[7:0];
            end
            OP_AND, OP_OR, OP_XOR: begin
                res_d.flags.cf = 1'b0;
                res_d.flags.of = 1'b0;
                res_d.flags.zf = (alu_res == 32'd0);
                res_d.flags.sf = r_top;
                res_d.flags.pf = ~^alu_res[7:0];
            end
            OP_JCC: begin
                res_d.branch = cond_taken;
            end
            default: begin
                // not and setcc keep the incoming flags
                res_d.branch = 1'b0;
            end
        endcase
    end

    // ----------------------------------------
    // one-entry result register
    // ----------------------------------------

    assign in_ready = !res_valid || res_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            res_q <= res_d;
        end
    end

    assign res = res_q;

endmodule

// File: src/exec_collect.sv
`timescale 1ns/1ps

module exec_collect (
    input  logic                                              clk,
    input  logic                                              rst_n,

    // from the lanes
    input  logic [exec_pkg::num_lanes-1:0]                    lane_res_valid,
    input  exec_pkg::exec_res_t [exec_pkg::num_lanes-1:0]     lane_res,
    output logic [exec_pkg::num_lanes-1:0]                    lane_res_ready,

    // result output port
    output logic                                              res_valid,
    output exec_pkg::exec_res_t                               res,
    input  logic                                              res_ready
);

    import exec_pkg::*;

    // lane that holds the oldest result
    logic [lane_idx_w-1:0] ptr;
    logic                  out_xfer;

    // ----------------------------------------
    // output mux
    // ----------------------------------------

    assign res_valid = lane_res_valid[ptr];
    assign res       = lane_res[ptr];
    assign out_xfer  = res_valid && res_ready;

    // only the turn lane may see ready
    always_comb begin
        lane_res_ready      = '0;
        lane_res_ready[ptr] = res_ready;
    end

    // ----------------------------------------
    // turn pointer
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (out_xfer) begin
            if (ptr == lane_idx_w'(num_lanes - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

// File: src/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 cmd_valid,
    input  exec_pkg::exec_cmd_t  cmd,
    output logic                 cmd_ready,

    output logic                 res_valid,
    output exec_pkg::exec_res_t  res,
    input  logic                 res_ready
);

    import exec_pkg::*;

    // dispatcher side
    logic [num_lanes-1:0]             lane_in_valid;
    logic [num_lanes-1:0]             lane_in_ready;
    exec_cmd_t                        lane_cmd;

    // collector side
    logic [num_lanes-1:0]             lane_res_valid;
    logic [num_lanes-1:0]             lane_res_ready;
    exec_res_t [num_lanes-1:0]        lane_res;

    exec_dispatch exec_dispatch_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_ready     (cmd_ready),
        .lane_in_valid (lane_in_valid),
        .lane_cmd      (lane_cmd),
        .lane_in_ready (lane_in_ready)
    );

    // ----------------------------------------
    // execute lanes
    // ----------------------------------------

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        exec_lane exec_lane_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (lane_in_valid[i]),
            .cmd       (lane_cmd),
            .in_ready  (lane_in_ready[i]),
            .res_valid (lane_res_valid[i]),
            .res       (lane_res[i]),
            .res_ready (lane_res_ready[i])
        );
    end

    exec_collect exec_collect_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .lane_res_valid (lane_res_valid),
        .lane_res       (lane_res),
        .lane_res_ready (lane_res_ready),
        .res_valid      (res_valid),
        .res            (res),
        .res_ready      (res_ready)
    );

endmodule

// File: dv/exec_cluster_tb.sv
`timescale 1ns/1ps

module exec_cluster_tb;

    import exec_pkg::*;

    // commands sent per test, sized for the watchdog
    localparam int arith_cmds = 120;
    localparam int logic_cmds = 48;
    localparam int setcc_cmds = 64;
    localparam int jcc_cmds   = 50;
    localparam int order_cmds = num_lanes + 41;
    localparam int total_cmds = arith_cmds + logic_cmds + setcc_cmds + jcc_cmds + order_cmds;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    exec_cmd_t   cmd;
    logic        cmd_ready;
    logic        res_valid;
    exec_res_t   res;
    logic        res_ready;

    logic [31:0] lfsr_state;
    exec_res_t   exp_q[$];
    string       cur_test;
    int          errors;
    int          test_errors;
    int          pass_count;
    int          fail_count;
    // 0 always ready, 1 held low, 2 random
    int          ready_mode;
    logic        ready_next;

    exec_cluster exec_cluster_i (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ----------------------------------------
    // stimulus helpers and reference model
    // ----------------------------------------

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic exec_cmd_t rand_cmd(input exec_op_e op, input exec_size_e sz);
        exec_cmd_t c;
        c.op    = op;
        c.size  = sz;
        c.cond  = 4'(rand_bits(4));
        c.src   = rand_bits(32);
        c.dst   = rand_bits(32);
        c.eip   = rand_bits(32);
        c.disp  = rand_bits(32);
        c.flags = exec_flags_t'(5'(rand_bits(5)));
        return c;
    endfunction

    function automatic logic cond_ref(input exec_flags_t f, input logic [3:0] idx);
        logic t;
        case (idx[3:1])
            3'd0:    t = f.of;
            3'd1:    t = f.cf;
            3'd2:    t = f.zf;
            3'd3:    t = f.cf || f.zf;
            3'd4:    t = f.sf;
            3'd5:    t = f.pf;
            3'd6:    t = f.sf != f.of;
            default: t = f.zf || (f.sf != f.of);
        endcase
        return idx[0] ? !t : t;
    endfunction

    // signed and unsigned views at the command size
    function automatic exec_res_t ref_model(input exec_cmd_t c);
        exec_res_t   e;
        int          w;
        longint      mask;
        longint      smax;
        longint      a;
        longint      b;
        longint      sa;
        longint      sb;
        longint      ci;
        longint      full;
        longint      sres;
        logic [31:0] r;
        w    = (c.size == SZ_8) ? 8 : (c.size == SZ_16) ? 16 : 32;
        mask = (longint'(1) << w) - 1;
        smax = mask >> 1;
        a    = longint'(c.dst) & mask;
        b    = longint'(c.src) & mask;
        sa   = (a > smax) ? a - (mask + 1) : a;
        sb   = (b > smax) ? b - (mask + 1) : b;
        ci   = ((c.op == OP_ADC || c.op == OP_SBB) && c.flags.cf) ? 1 : 0;
        e       = '0;
        e.flags = c.flags;
        r       = '0;
        case (c.op)
            OP_ADD, OP_ADC, OP_SUB, OP_SBB: begin
                if (c.op == OP_ADD || c.op == OP_ADC) begin
                    full       = a + b + ci;
                    sres       = sa + sb + ci;
                    e.flags.cf = full > mask;
                end else begin
                    full       = a - b - ci;
                    sres       = sa - sb - ci;
                    e.flags.cf = full < 0;
                end
                r          = 32'(full & mask);
                e.flags.of = (sres > smax) || (sres < -smax - 1);
            end
            OP_AND:   r = 32'(a & b);
            OP_OR:    r = 32'(a | b);
            OP_XOR:   r = 32'(a ^ b);
            OP_NOT:   r = ~c.dst & 32'(mask);
            OP_SETCC: r = {31'd0, cond_ref(c.flags, c.cond)};
            OP_JCC: begin
                e.branch = cond_ref(c.flags, c.cond);
                full     = longint'(c.disp) & mask;
                full     = (full > smax) ? full - (mask + 1) : full;
                e.branch_eip = 32'(longint'(c.eip) + full);
                if (c.size == SZ_16) begin
                    e.branch_eip = e.branch_eip & 32'h0000_ffff;
                end
            end
            default: r = '0;
        endcase
        if (c.op inside {OP_ADD, OP_ADC, OP_SUB, OP_SBB, OP_AND, OP_OR, OP_XOR}) begin
            e.flags.zf = r == 32'd0;
            e.flags.sf = r[w-1];
            e.flags.pf = ($countones(r[7:0]) % 2) == 0;
        end
        if (c.op inside {OP_AND, OP_OR, OP_XOR}) begin
            e.flags.cf = 1'b0;
            e.flags.of = 1'b0;
        end
        e.result = r;
        return e;
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic check_res(input string name, input exec_res_t exp, input exec_res_t act);
        logic bad;
        bad = (exp.result !== act.result) || (exp.flags !== act.flags)
              || (exp.branch !== act.branch);
        if (exp.branch && (exp.branch_eip !== act.branch_eip)) begin
            bad = 1'b1;
        end
        if (bad) begin
            $display("ERROR %s: expected result %h flags %b branch %b target %h, %s %h %b %b %h",
                     name, exp.result, exp.flags, exp.branch, exp.branch_eip,
                     "actual", act.result, act.flags, act.branch, act.branch_eip);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERROR %s: expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    // ----------------------------------------
    // handshake processes
    // ----------------------------------------

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        case (ready_mode)
            0:       ready_next = 1'b1;
            1:       ready_next = 1'b0;
            default: ready_next = rand_bits(1) != 0;
        endcase
        if (rst_n && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                $display("%s: a result came out with no command outstanding", cur_test);
                errors++;
            end else begin
                check_res(cur_test, exp_q.pop_front(), res);
            end
        end
    end

    always @(posedge clk) begin
        #2;
        res_ready = ready_next;
    end

    task automatic send_cmd(input exec_cmd_t c);
        logic took;
        cmd_valid = 1'b1;
        cmd       = c;
        exp_q.push_back(ref_model(c));
        took = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = cmd_ready;
            @(posedge clk);
            #2;
        end
        cmd_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
        ready_mode  = 0;
    endtask

    task automatic finish_test();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 100) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d results never came out of the cluster", cur_test, exp_q.size());
            errors++;
            exp_q.delete();
        end
        if (errors == test_errors) begin
            $display("test %s passed", cur_test);
            pass_count++;
        end else begin
            $display("test %s failed with %0d errors", cur_test, errors - test_errors);
            fail_count++;
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    task automatic test_reset();
        start_test("reset");
        @(negedge clk);
        check_bit("reset res_valid", 1'b0, res_valid);
        check_bit("reset cmd_ready", 1'b1, cmd_ready);
        @(posedge clk);
        #2;
        finish_test();
    endtask

    task automatic test_arith();
        exec_cmd_t   c;
        logic [31:0] m;
        start_test("arith");
        for (int s = 0; s < 3; s++) begin
            m = (s == 0) ? 32'h0000_00ff : (s == 1) ? 32'h0000_ffff : 32'hffff_ffff;
            for (int k = 0; k < 4; k++) begin
                for (int n = 0; n < 10; n++) begin
                    c = rand_cmd(exec_op_e'(4'(k)), exec_size_e'(2'(s)));
                    if (n < 4) begin
                        // sign boundary, carry out, most negative, equal operands
                        c.dst      = (n == 0) ? m >> 1 : (n == 1) ? m
                                   : (n == 2) ? (m >> 1) + 1 : c.src;
                        c.src      = (n < 3) ? 32'd1 : c.src;
                        c.flags.cf = 1'b0;
                    end
                    send_cmd(c);
                end
            end
        end
        finish_test();
    endtask

    task automatic test_logic();
        start_test("logic");
        for (int s = 0; s < 3; s++) begin
            for (int k = 4; k < 8; k++) begin
                repeat (4) send_cmd(rand_cmd(exec_op_e'(4'(k)), exec_size_e'(2'(s))));
            end
        end
        finish_test();
    endtask

    task automatic test_setcc();
        exec_cmd_t  c;
        exec_size_e sz;
        start_test("setcc");
        for (int j = 0; j < 16; j++) begin
            repeat (4) begin
                sz     = exec_size_e'(2'(rand_bits(2) % 3));
                c      = rand_cmd(OP_SETCC, sz);
                c.cond = 4'(j);
                send_cmd(c);
            end
        end
        finish_test();
    endtask

    task automatic test_jcc();
        exec_cmd_t c;
        start_test("jcc");
        for (int s = 0; s < 3; s++) begin
            for (int j = 0; j < 16; j++) begin
                c      = rand_cmd(OP_JCC, exec_size_e'(2'(s)));
                c.cond = 4'(j);
                send_cmd(c);
            end
        end
        // taken jump with a negative 8-bit displacement
        c          = rand_cmd(OP_JCC, SZ_8);
        c.cond     = 4'd0;
        c.flags.of = 1'b1;
        c.eip      = 32'h0000_1000;
        c.disp     = 32'h0000_00f0;
        send_cmd(c);
        // 16-bit target wraps past 0xffff
        c.size = SZ_16;
        c.eip  = 32'h0001_fff0;
        c.disp = 32'h0000_0020;
        send_cmd(c);
        finish_test();
    endtask

    task automatic test_order();
        exec_cmd_t  c;
        exec_op_e   op;
        exec_size_e sz;
        logic       took;
        start_test("order");
        ready_mode = 1;
        repeat (3) @(posedge clk);
        #2;
        took = 1'b1;
        for (int i = 0; i <= num_lanes && took; i++) begin
            c         = rand_cmd(OP_ADD, SZ_32);
            cmd_valid = 1'b1;
            cmd       = c;
            @(negedge clk);
            took = cmd_ready;
            check_bit("order cmd_ready", i < num_lanes, took);
            if (took) begin
                exp_q.push_back(ref_model(c));
            end
            @(posedge clk);
            #2;
        end
        ready_mode = 0;
        // the refused command stays pending with the same payload
        if (!took) begin
            send_cmd(c);
        end
        cmd_valid  = 1'b0;
        ready_mode = 2;
        repeat (40) begin
            op = exec_op_e'(4'(rand_bits(4) % 10));
            sz = exec_size_e'(2'(rand_bits(2) % 3));
            send_cmd(rand_cmd(op, sz));
        end
        finish_test();
    endtask

    // ----------------------------------------
    // main sequence and watchdog
    // ----------------------------------------

    initial begin
        lfsr_state = 32'd46;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        ready_mode = 0;
        ready_next = 1'b1;
        cur_test   = "init";
        cmd_valid  = 1'b0;
        cmd        = '0;
        res_ready  = 1'b1;
        rst_n      = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_arith();
        test_logic();
        test_setcc();
        test_jcc();
        test_order();
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (total_cmds * 20) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: files.f
src/exec_pkg.sv
src/exec_condition.sv
src/exec_dispatch.sv
src/exec_lane.sv
src/exec_collect.sv
src/exec_cluster.sv
dv/exec_cluster_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the exec cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f files.f --top-module exec_cluster_tb -o exec_cluster_sim \
    && ./obj_dir/exec_cluster_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation PASSED"
exit 0
